/* design/tpu_pkg.sv */
// tpu package
// sizes, element and buffer word types, bus structs and state enums
// shared by every block of the systolic matrix multiplier

package tpu_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////
	localparam int DATA_W    = 8;
	localparam int ARRAY_DIM = 4;
	localparam int WORD_W    = ARRAY_DIM * DATA_W;
	localparam int BUF_DEPTH = 16;
	localparam int ADDR_W    = 4;

	//////////////////////////////
	// data types
	//////////////////////////////
	typedef logic [DATA_W-1:0] elem_t;
	typedef elem_t [0:ARRAY_DIM-1] word_t;   // lane 0 in the top byte
	typedef word_t [0:ARRAY_DIM-1] result_t; // row r of C per word
	typedef logic [4:0] dim_t;               // m, n, k
	typedef logic [ADDR_W-1:0] addr_t;

	typedef enum logic {BUF_A, BUF_B} buf_sel_e;

	typedef struct packed {
		logic     en;
		buf_sel_e sel;
		addr_t    addr;
		word_t    data;
	} host_wr_t;

	typedef struct packed {
		logic  en;
		addr_t addr;
		word_t data;
	} buf_wr_t;

	typedef struct packed {
		word_t a; // lane i enters row i
		word_t b; // lane j enters column j
	} array_edge_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_CLEAR, ST_FETCH, ST_SHIFT, ST_MAC, ST_WRITE, ST_DONE
	} ctrl_state_e;

endpackage

/* design/global_buffer.sv */
// global buffer
// word memory with one synchronous write port and a registered read port

`timescale 1ns/1ps

module global_buffer import tpu_pkg::*; #(
	parameter int DEPTH = BUF_DEPTH
) (
	input  logic    clk,
	input  logic    rst,
	input  buf_wr_t wr_i,
	input  addr_t   rd_addr_i,
	output word_t   rd_data_o
);

	word_t mem [DEPTH];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			rd_data_o <= '0;
		end else begin
			if (wr_i.en) begin
				mem[wr_i.addr] <= wr_i.data;
			end
			rd_data_o <= mem[rd_addr_i]; // one cycle read latency
		end
	end

endmodule

/* design/operand_feeder.sv */
// operand feeder
// masks unused A and B lanes and skews them diagonally onto the array
// edges, lane i delayed by i shift steps

`timescale 1ns/1ps

module operand_feeder import tpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        clear_i,
	input  logic        shift_i,
	input  logic        feed_valid_i,
	input  word_t       a_word_i,
	input  word_t       b_word_i,
	input  dim_t        m_i,
	input  dim_t        n_i,
	output array_edge_t edge_o
);

	word_t a_in;
	word_t b_in;

	//////////////////////////////
	// lane masking
	//////////////////////////////
	always_comb begin
		for (int l = 0; l < ARRAY_DIM; l++) begin
			// rows beyond m and columns beyond n stay zero
			a_in[l] = (feed_valid_i && (l < m_i)) ? a_word_i[l] : '0;
			b_in[l] = (feed_valid_i && (l < n_i)) ? b_word_i[l] : '0;
		end
	end

	//////////////////////////////
	// skew triangle
	//////////////////////////////
	for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
		elem_t a_sr [0:i]; // i+1 stages for lane i
		elem_t b_sr [0:i];

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				a_sr <= '{default: '0};
				b_sr <= '{default: '0};
			end else if (clear_i) begin
				a_sr <= '{default: '0};
				b_sr <= '{default: '0};
			end else if (shift_i) begin
				a_sr[0] <= a_in[i];
				b_sr[0] <= b_in[i];
				for (int d = 1; d <= i; d++) begin
					a_sr[d] <= a_sr[d-1];
					b_sr[d] <= b_sr[d-1];
				end
			end
		end

		assign edge_o.a[i] = a_sr[i]; // oldest stage drives the edge
		assign edge_o.b[i] = b_sr[i];
	end

endmodule

/* design/systolic_array.sv */
// systolic array
// 4x4 output-stationary grid of 8-bit multiply-accumulate cells,
// A moves right and B moves down one cell per mac step

`timescale 1ns/1ps

module systolic_array import tpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        clear_i,
	input  logic        mac_i,
	input  array_edge_t edge_i,
	output result_t     result_o
);

	elem_t a_in   [ARRAY_DIM][ARRAY_DIM];   // operands seen by each cell
	elem_t b_in   [ARRAY_DIM][ARRAY_DIM];
	elem_t a_pass [ARRAY_DIM][ARRAY_DIM-1]; // between columns
	elem_t b_pass [ARRAY_DIM-1][ARRAY_DIM]; // between rows
	elem_t acc    [ARRAY_DIM][ARRAY_DIM];

	for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_row
		for (genvar j = 0; j < ARRAY_DIM; j++) begin : g_col
			elem_t prod;

			//////////////////////////////
			// operand sources
			//////////////////////////////
			if (j == 0) begin : g_a_edge
				assign a_in[i][j] = edge_i.a[i];
			end else begin : g_a_left
				assign a_in[i][j] = a_pass[i][j-1];
			end

			if (i == 0) begin : g_b_edge
				assign b_in[i][j] = edge_i.b[j];
			end else begin : g_b_up
				assign b_in[i][j] = b_pass[i-1][j];
			end

			assign prod = a_in[i][j] * b_in[i][j]; // wraps to 8 bits

			//////////////////////////////
			// accumulator
			//////////////////////////////
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					acc[i][j] <= '0;
				end else if (clear_i) begin
					acc[i][j] <= '0;
				end else if (mac_i) begin
					acc[i][j] <= acc[i][j] + prod;
				end
			end

			// pass registers, none past the last column or row
			if (j < ARRAY_DIM - 1) begin : g_a_pass
				always_ff @(posedge clk or posedge rst) begin
					if (rst) begin
						a_pass[i][j] <= '0;
					end else if (clear_i) begin
						a_pass[i][j] <= '0;
					end else if (mac_i) begin
						a_pass[i][j] <= a_in[i][j];
					end
				end
			end

			if (i < ARRAY_DIM - 1) begin : g_b_pass
				always_ff @(posedge clk or posedge rst) begin
					if (rst) begin
						b_pass[i][j] <= '0;
					end else if (clear_i) begin
						b_pass[i][j] <= '0;
					end else if (mac_i) begin
						b_pass[i][j] <= b_in[i][j];
					end
				end
			end

			assign result_o[i][j] = acc[i][j];
		end
	end

endmodule

/* design/result_writer.sv */
// result writer
// copies the first m accumulator rows into the result buffer,
// one row per cycle, row r to address r

`timescale 1ns/1ps

module result_writer import tpu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    write_start_i,
	input  dim_t    m_i,
	input  result_t result_i,
	output buf_wr_t wr_o,
	output logic    write_done_o
);

	localparam int ROW_W = $clog2(ARRAY_DIM);

	logic             active;
	logic [ROW_W-1:0] row;
	logic             last_row;

	assign last_row = (dim_t'(row) == dim_t'(m_i - 1'b1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			row    <= '0;
		end else if (write_start_i) begin
			active <= 1'b1;
			row    <= '0;
		end else if (active) begin
			if (last_row) begin
				active <= 1'b0; // rows at and beyond m untouched
			end
			row <= row + 1'b1;
		end
	end

	assign wr_o.en      = active;
	assign wr_o.addr    = addr_t'(row);
	assign wr_o.data    = result_i[row];
	assign write_done_o = active && last_row; // with the last write

endmodule

/* design/tpu_ctrl.sv */
// tpu controller
// run FSM and step counter, each step is fetch, shift and mac,
// followed by the result write and a held done level

`timescale 1ns/1ps

module tpu_ctrl import tpu_pkg::*; #(
	parameter int DEPTH = BUF_DEPTH
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  start_i,
	input  dim_t  k_i,
	input  logic  write_done_i,
	output addr_t rd_addr_o,
	output logic  feed_valid_o,
	output logic  shift_o,
	output logic  mac_o,
	output logic  clear_o,
	output logic  write_start_o,
	output logic  done_o
);

	// k + 2*ARRAY_DIM - 2 steps at most
	localparam int STEP_W = $clog2(DEPTH + 2 * ARRAY_DIM - 1);

	ctrl_state_e       state;
	ctrl_state_e       state_nxt;
	logic [STEP_W-1:0] step;
	logic              last_step;
	logic              start_ok;

	assign start_ok  = start_i && (state == ST_IDLE || state == ST_DONE);
	assign last_step = (step == STEP_W'(k_i) + STEP_W'(2 * ARRAY_DIM - 3));

	//////////////////////////////
	// state machine
	//////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start_ok)
					state_nxt = ST_CLEAR;
			end
			ST_CLEAR: state_nxt = ST_FETCH;
			ST_FETCH: state_nxt = ST_SHIFT;
			ST_SHIFT: state_nxt = ST_MAC;
			ST_MAC: begin
				state_nxt = last_step ? ST_WRITE : ST_FETCH;
			end
			ST_WRITE: begin
				if (write_done_i)
					state_nxt = ST_DONE;
			end
			ST_DONE: begin
				if (start_ok)
					state_nxt = ST_CLEAR; // back to back run
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// step number, advanced after every mac
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			step <= '0;
		end else if (state == ST_CLEAR) begin
			step <= '0;
		end else if (state == ST_MAC && !last_step) begin
			step <= step + 1'b1;
		end
	end

	//////////////////////////////
	// outputs
	//////////////////////////////
	assign rd_addr_o     = addr_t'(step); // only used while step < k
	assign feed_valid_o  = (state == ST_SHIFT) && (step < STEP_W'(k_i));
	assign shift_o       = (state == ST_SHIFT);
	assign mac_o         = (state == ST_MAC);
	assign clear_o       = (state == ST_CLEAR);
	assign write_start_o = (state == ST_MAC) && last_step;
	assign done_o        = (state == ST_DONE);

endmodule

/* design/tpu_top.sv */
// tpu top level
// connects controller, operand feeder, systolic array, result writer
// and the A, B and result buffers

`timescale 1ns/1ps

module tpu_top import tpu_pkg::*; #(
	parameter int BUF_DEPTH = tpu_pkg::BUF_DEPTH
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     start_i,
	input  dim_t     m_i,
	input  dim_t     n_i,
	input  dim_t     k_i,
	input  host_wr_t host_wr_i,
	input  addr_t    host_rd_addr_i,
	output word_t    host_rd_data_o,
	output logic     done_o
);

	buf_wr_t     a_wr;
	buf_wr_t     b_wr;
	buf_wr_t     out_wr;
	addr_t       rd_addr;
	word_t       a_word;
	word_t       b_word;
	logic        feed_valid;
	logic        shift;
	logic        mac;
	logic        clear;
	logic        write_start;
	logic        write_done;
	array_edge_t array_edge;
	result_t     result;

	// host writes go to A or B by sel
	assign a_wr = '{en: host_wr_i.en && (host_wr_i.sel == BUF_A),
		addr: host_wr_i.addr, data: host_wr_i.data};
	assign b_wr = '{en: host_wr_i.en && (host_wr_i.sel == BUF_B),
		addr: host_wr_i.addr, data: host_wr_i.data};

	//////////////////////////////
	// engine
	//////////////////////////////
	tpu_ctrl #(.DEPTH(BUF_DEPTH)) i_tpu_ctrl (
		.clk(clk), .rst(rst), .start_i(start_i), .k_i(k_i),
		.write_done_i(write_done), .rd_addr_o(rd_addr),
		.feed_valid_o(feed_valid), .shift_o(shift), .mac_o(mac),
		.clear_o(clear), .write_start_o(write_start), .done_o(done_o)
	);

	operand_feeder i_operand_feeder (
		.clk(clk), .rst(rst), .clear_i(clear), .shift_i(shift),
		.feed_valid_i(feed_valid), .a_word_i(a_word), .b_word_i(b_word),
		.m_i(m_i), .n_i(n_i), .edge_o(array_edge)
	);

	systolic_array i_systolic_array (
		.clk(clk), .rst(rst), .clear_i(clear), .mac_i(mac),
		.edge_i(array_edge), .result_o(result)
	);

	result_writer i_result_writer (
		.clk(clk), .rst(rst), .write_start_i(write_start), .m_i(m_i),
		.result_i(result), .wr_o(out_wr), .write_done_o(write_done)
	);

	//////////////////////////////
	// buffers
	//////////////////////////////
	global_buffer #(.DEPTH(BUF_DEPTH)) i_buf_a (
		.clk(clk), .rst(rst), .wr_i(a_wr), .rd_addr_i(rd_addr), .rd_data_o(a_word)
	);

	global_buffer #(.DEPTH(BUF_DEPTH)) i_buf_b (
		.clk(clk), .rst(rst), .wr_i(b_wr), .rd_addr_i(rd_addr), .rd_data_o(b_word)
	);

	global_buffer #(.DEPTH(BUF_DEPTH)) i_buf_out (
		.clk(clk), .rst(rst), .wr_i(out_wr), .rd_addr_i(host_rd_addr_i),
		.rd_data_o(host_rd_data_o)
	);

endmodule

/* verification/tb_tpu.sv */
// tpu testbench
// directed runs of the systolic matrix multiplier against a wrapped 8-bit
// reference model of C = A*B, with a watchdog on the whole run

`timescale 1ns/1ps

module tb_tpu import tpu_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RUN_CYCLES = 3 * (BUF_DEPTH + 2 * ARRAY_DIM - 2) + 12;
	localparam int IO_CYCLES  = 2 * BUF_DEPTH + 3 * BUF_DEPTH + 8; // loads and reads
	localparam int NUM_RUNS   = 11;

	logic     clk;
	logic     rst;
	logic     start_i;
	dim_t     m_i;
	dim_t     n_i;
	dim_t     k_i;
	host_wr_t host_wr_i;
	addr_t    host_rd_addr_i;
	word_t    host_rd_data_o;
	logic     done_o;

	integer seed = 32'h52ae;
	elem_t  mat_a [ARRAY_DIM][BUF_DEPTH]; // m x k
	elem_t  mat_b [BUF_DEPTH][ARRAY_DIM]; // k x n
	word_t  exp_c [ARRAY_DIM];            // model of result buffer rows

	tpu_top #(.BUF_DEPTH(BUF_DEPTH)) i_tpu_top (
		.clk(clk), .rst(rst), .start_i(start_i), .m_i(m_i), .n_i(n_i), .k_i(k_i),
		.host_wr_i(host_wr_i), .host_rd_addr_i(host_rd_addr_i),
		.host_rd_data_o(host_rd_data_o), .done_o(done_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// watchdog sized from the number of runs
	initial begin
		#(NUM_RUNS * (RUN_CYCLES + IO_CYCLES) * CLK_PERIOD + 200 * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in time");
		$display("Done: errors found");
		$fatal(1);
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic void model_run(input int m, input int n, input int k);
		elem_t sum;
		for (int r = 0; r < m; r++) begin
			for (int j = 0; j < ARRAY_DIM; j++) begin
				sum = '0;
				for (int t = 0; t < k; t++) begin
					sum += mat_a[r][t] * mat_b[t][j]; // wraps to 8 bits
				end
				exp_c[r][j] = (j < n) ? sum : '0;
			end
		end
	endfunction

	task automatic fill_random(input int k);
		for (int t = 0; t < k; t++) begin
			for (int l = 0; l < ARRAY_DIM; l++) begin
				mat_a[l][t] = elem_t'($random(seed));
				mat_b[t][l] = elem_t'($random(seed));
			end
		end
	endtask

	//////////////////////////////
	// DUT access
	//////////////////////////////
	task automatic load_matrices(input int k);
		word_t a_word;
		word_t b_word;
		for (int t = 0; t < k; t++) begin
			for (int l = 0; l < ARRAY_DIM; l++) begin
				a_word[l] = mat_a[l][t]; // column t of A
				b_word[l] = mat_b[t][l]; // row t of B
			end
			@(posedge clk);
			host_wr_i <= '{en: 1'b1, sel: BUF_A, addr: addr_t'(t), data: a_word};
			@(posedge clk);
			host_wr_i <= '{en: 1'b1, sel: BUF_B, addr: addr_t'(t), data: b_word};
		end
		@(posedge clk);
		host_wr_i.en <= 1'b0;
	endtask

	task automatic run_and_wait(input int m, input int n, input int k);
		int cycles;
		@(posedge clk);
		m_i     <= dim_t'(m);
		n_i     <= dim_t'(n);
		k_i     <= dim_t'(k);
		start_i <= 1'b1;
		@(posedge clk);
		start_i <= 1'b0;
		@(negedge clk);
		check_level("done_o", 1'b0, done_o); // falls after an accepted start
		cycles = 0;
		while (done_o !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > RUN_CYCLES) begin
				$display("timeout: done_o did not rise after start_i");
				$display("Done: errors found");
				$fatal(1);
			end
		end
		if (cycles != 1 + 3 * (k + 2 * ARRAY_DIM - 2) + m) begin
			$display("mismatch at %0t: run latency expected %0d got %0d", $time,
				1 + 3 * (k + 2 * ARRAY_DIM - 2) + m, cycles);
			$display("Done: errors found");
			$fatal(1);
		end
		model_run(m, n, k);
	endtask

	task automatic read_result(input addr_t addr, output word_t data);
		@(posedge clk);
		host_rd_addr_i <= addr;
		@(posedge clk); // registered read
		@(negedge clk);
		data = host_rd_data_o;
	endtask

	task automatic check_rows();
		word_t data;
		for (int r = 0; r < ARRAY_DIM; r++) begin
			read_result(addr_t'(r), data);
			check_word($sformatf("host_rd_data_o[%0d]", r), exp_c[r], data);
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_reset();
		word_t data;
		check_level("done_o", 1'b0, done_o);
		for (int r = 0; r < BUF_DEPTH; r++) begin
			read_result(addr_t'(r), data);
			check_word($sformatf("host_rd_data_o[%0d]", r), '0, data);
		end
	endtask

	task automatic test_identity();
		word_t data;
		word_t a_row;
		fill_random(ARRAY_DIM);
		for (int t = 0; t < ARRAY_DIM; t++) begin
			for (int j = 0; j < ARRAY_DIM; j++) begin
				mat_b[t][j] = (t == j) ? 8'd1 : 8'd0;
			end
		end
		load_matrices(ARRAY_DIM);
		run_and_wait(ARRAY_DIM, ARRAY_DIM, ARRAY_DIM);
		for (int r = 0; r < ARRAY_DIM; r++) begin
			for (int j = 0; j < ARRAY_DIM; j++) begin
				a_row[j] = mat_a[r][j];
			end
			read_result(addr_t'(r), data);
			check_word($sformatf("host_rd_data_o[%0d]", r), a_row, data);
		end
		repeat (5) @(negedge clk);
		check_level("done_o", 1'b1, done_o); // level held after the run
	endtask

	task automatic test_random();
		int k;
		for (int i = 0; i < 6; i++) begin
			if (i == 0)
				k = 1;
			else if (i == 5)
				k = BUF_DEPTH;
			else
				k = 1 + ($unsigned($random(seed)) % BUF_DEPTH);
			fill_random(k);
			load_matrices(k);
			run_and_wait(ARRAY_DIM, ARRAY_DIM, k);
			check_rows();
		end
	endtask

	task automatic test_partial();
		fill_random(ARRAY_DIM);
		load_matrices(ARRAY_DIM);
		run_and_wait(ARRAY_DIM, ARRAY_DIM, ARRAY_DIM);
		check_rows();
		fill_random(5);
		load_matrices(5);
		run_and_wait(2, 3, 5); // rows 2 and 3 keep the old model values
		check_rows();
	endtask

	task automatic test_back_to_back();
		fill_random(BUF_DEPTH);
		load_matrices(BUF_DEPTH);
		run_and_wait(ARRAY_DIM, ARRAY_DIM, BUF_DEPTH);
		check_rows();
		run_and_wait(ARRAY_DIM, ARRAY_DIM, 2); // restart straight from done
		check_rows();
	endtask

	initial begin
		rst            = 1'b1;
		start_i        = 1'b0;
		m_i            = '0;
		n_i            = '0;
		k_i            = '0;
		host_wr_i      = '0;
		host_rd_addr_i = '0;
		for (int r = 0; r < ARRAY_DIM; r++) begin
			exp_c[r] = '0;
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_identity();
		test_random();
		test_partial();
		test_back_to_back();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* src.f */
design/tpu_pkg.sv
design/global_buffer.sv
design/operand_feeder.sv
design/systolic_array.sv
design/result_writer.sv
design/tpu_ctrl.sv
design/tpu_top.sv
verification/tb_tpu.sv
